// File: verilog/prefetch_cfg.svh
`ifndef PREFETCH_CFG_SVH
`define PREFETCH_CFG_SVH

// FIFO depth, also the cap on outstanding bus transactions
`define PF_DEPTH 4

// Occupancy and outstanding counts must hold the depth itself
`define PF_CNT_W 3

// Address and instruction word width
`define PF_XLEN 32

`endif

// File: verilog/prefetch_pkg.sv
`include "prefetch_cfg.svh"

package prefetch_pkg;

  // Byte address on the instruction bus
  typedef logic [`PF_XLEN-1:0] addr_t;

  // Fetched instruction word
  typedef logic [`PF_XLEN-1:0] instr_t;

  // FIFO occupancy and outstanding transaction count
  typedef logic [`PF_CNT_W-1:0] cnt_t;

  // Controller state
  // Branch wait replays the target until the bus grants it
  typedef enum logic {
    CTRL_IDLE        = 1'b0,
    CTRL_BRANCH_WAIT = 1'b1
  } ctrl_state_e;

endpackage

// File: verilog/prefetch_ctrl.sv
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module prefetch_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,

  // Fetch stage side
  input  logic                  req_i,
  input  logic                  branch_i,
  input  prefetch_pkg::addr_t   branch_addr_i,
  input  logic                  fetch_ready_i,
  output logic                  fetch_valid_o,
  output logic                  busy_o,

  // Bus request and response strobes
  output logic                  instr_req_o,
  output prefetch_pkg::addr_t   instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,

  // FIFO control and status
  output logic                  fifo_push_o,
  output logic                  fifo_pop_o,
  output logic                  fifo_flush_o,
  input  prefetch_pkg::cnt_t    fifo_cnt_i,
  input  logic                  fifo_empty_i
);

  import prefetch_pkg::*;

  // FSM
  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Outstanding transactions on the bus
  cnt_t        out_cnt_q;
  cnt_t        out_cnt_d;
  logic        count_up;
  logic        count_down;

  // Responses still to be dropped after a branch
  cnt_t        flush_cnt_q;
  cnt_t        flush_cnt_d;
  logic        flushing;

  // Address of the last accepted (or pending branch) transaction
  addr_t       addr_q;
  addr_t       addr_incr;
  addr_t       aligned_target;

  // One extra bit so the sum never wraps
  logic [`PF_CNT_W:0] fill_sum;

  logic        trans_accept;

  ////////////////////
  // Status
  ////////////////////

  // Busy while anything is in flight or being requested
  assign busy_o = (out_cnt_q != '0) || instr_req_o;

  assign flushing = (flush_cnt_q != '0);

  // Head of FIFO or a response on its way through
  // Never valid in the branch cycle or while stale responses drain
  assign fetch_valid_o = (!fifo_empty_i || instr_rvalid_i) && !(branch_i || flushing);

  ////////////////////
  // Request generation
  ////////////////////

  // Word fetches only
  assign aligned_target = {branch_addr_i[`PF_XLEN-1:2], 2'b00};
  assign addr_incr      = addr_q + addr_t'(4);

  // Words held plus words still coming back
  assign fill_sum = {1'b0, fifo_cnt_i} + {1'b0, out_cnt_q};

  // Room must exist for every response we ask for
  assign instr_req_o  = req_i && (fill_sum < (`PF_CNT_W+1)'(`PF_DEPTH));
  assign trans_accept = instr_req_o && instr_gnt_i;

  always_comb begin
    state_d      = state_q;
    instr_addr_o = addr_q;

    unique case (state_q)
      CTRL_IDLE: begin
        if (branch_i) begin
          instr_addr_o = aligned_target;
        end else begin
          instr_addr_o = addr_incr;
        end
        // Branch target not taken by the bus yet
        if (branch_i && !trans_accept) begin
          state_d = CTRL_BRANCH_WAIT;
        end
      end

      CTRL_BRANCH_WAIT: begin
        // Replay stored target, a newer branch overrides it
        instr_addr_o = branch_i ? aligned_target : addr_q;
        if (trans_accept) begin
          state_d = CTRL_IDLE;
        end
      end

      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  ////////////////////
  // FIFO control
  ////////////////////

  // Responses skip the FIFO when it is empty and the consumer takes them
  assign fifo_push_o  = instr_rvalid_i && (!fifo_empty_i || !fetch_ready_i) &&
                        !(branch_i || flushing);
  assign fifo_pop_o   = !fifo_empty_i && fetch_ready_i;

  // Held words are stale once a branch is taken
  assign fifo_flush_o = branch_i;

  ////////////////////
  // Counters
  ////////////////////

  assign count_up   = trans_accept;
  assign count_down = instr_rvalid_i;

  always_comb begin
    unique case ({count_up, count_down})
      2'b10:   out_cnt_d = out_cnt_q + cnt_t'(1);
      2'b01:   out_cnt_d = out_cnt_q - cnt_t'(1);
      default: out_cnt_d = out_cnt_q;
    endcase
  end

  // At a branch every transaction already in flight is stale
  // the grant of the branch itself is not among them
  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      flush_cnt_d = out_cnt_q;
      // A response arriving right now is dropped already
      if (instr_rvalid_i && (out_cnt_q != '0)) begin
        flush_cnt_d = out_cnt_q - cnt_t'(1);
      end
    end else if (instr_rvalid_i && flushing) begin
      flush_cnt_d = flush_cnt_q - cnt_t'(1);
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= CTRL_IDLE;
      out_cnt_q   <= '0;
      flush_cnt_q <= '0;
      addr_q      <= '0;
    end else begin
      state_q     <= state_d;
      out_cnt_q   <= out_cnt_d;
      flush_cnt_q <= flush_cnt_d;
      // Keep the target for replay, or the last granted address
      if (branch_i || trans_accept) begin
        addr_q <= instr_addr_o;
      end
    end
  end

endmodule

// File: verilog/fetch_fifo.sv
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module fetch_fifo (
  input  logic                  clk,
  input  logic                  rst_n,

  // Control from the prefetch controller
  input  logic                  push_i,
  input  logic                  pop_i,
  input  logic                  flush_i,

  // Incoming bus response
  input  prefetch_pkg::instr_t  in_rdata_i,

  // Status and output word
  output prefetch_pkg::cnt_t    count_o,
  output logic                  empty_o,
  output prefetch_pkg::instr_t  out_rdata_o
);

  import prefetch_pkg::*;

  localparam int PTR_W = (`PF_DEPTH > 1) ? $clog2(`PF_DEPTH) : 1;

  // Storage
  instr_t             mem_q [`PF_DEPTH];

  // Pointers and occupancy
  logic [PTR_W-1:0]   rptr_q;
  logic [PTR_W-1:0]   wptr_q;
  logic [PTR_W-1:0]   rptr_next;
  logic [PTR_W-1:0]   wptr_next;
  cnt_t               cnt_q;

  ////////////////////
  // Status and output
  ////////////////////

  assign count_o = cnt_q;
  assign empty_o = (cnt_q == '0);

  // Fall through when empty, the response goes straight out
  assign out_rdata_o = empty_o ? in_rdata_i : mem_q[rptr_q];

  ////////////////////
  // Pointer arithmetic
  ////////////////////

  // Wrap at depth, works for depths that are not a power of two
  assign rptr_next = (rptr_q == PTR_W'(`PF_DEPTH - 1)) ? '0 : rptr_q + PTR_W'(1);
  assign wptr_next = (wptr_q == PTR_W'(`PF_DEPTH - 1)) ? '0 : wptr_q + PTR_W'(1);

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      // Whole buffer dropped in one cycle
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= wptr_next;
      end
      if (pop_i) begin
        rptr_q <= rptr_next;
      end
      // Push and pop together leave the count alone
      unique case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////
  // Storage write
  ////////////////////

  // Controller never pushes into a full buffer
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wptr_q] <= in_rdata_i;
    end
  end

endmodule

// File: verilog/prefetch_buffer.sv
`timescale 1ns/100ps

module prefetch_buffer (
  input  logic                  clk,
  input  logic                  rst_n,

  // Fetch stage
  input  logic                  req_i,
  input  logic                  branch_i,
  input  prefetch_pkg::addr_t   branch_addr_i,
  input  logic                  fetch_ready_i,
  output logic                  fetch_valid_o,
  output prefetch_pkg::instr_t  fetch_rdata_o,
  output logic                  busy_o,

  // Instruction bus
  output logic                  instr_req_o,
  output prefetch_pkg::addr_t   instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  prefetch_pkg::instr_t  instr_rdata_i
);

  import prefetch_pkg::*;

  // Controller to FIFO
  logic fifo_push;
  logic fifo_pop;
  logic fifo_flush;
  cnt_t fifo_cnt;
  logic fifo_empty;

  ////////////////////
  // Controller
  ////////////////////

  prefetch_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .fetch_ready_i  (fetch_ready_i),
    .fetch_valid_o  (fetch_valid_o),
    .busy_o         (busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .fifo_push_o    (fifo_push),
    .fifo_pop_o     (fifo_pop),
    .fifo_flush_o   (fifo_flush),
    .fifo_cnt_i     (fifo_cnt),
    .fifo_empty_i   (fifo_empty)
  );

  ////////////////////
  // Instruction FIFO
  ////////////////////

  // Response data enters here, head or bypass goes to fetch
  fetch_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (fifo_push),
    .pop_i       (fifo_pop),
    .flush_i     (fifo_flush),
    .in_rdata_i  (instr_rdata_i),
    .count_o     (fifo_cnt),
    .empty_o     (fifo_empty),
    .out_rdata_o (fetch_rdata_o)
  );

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released just after an edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// File: dv/prefetch_assertions.sv
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module prefetch_assertions (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic                  branch_i,
  input  prefetch_pkg::addr_t   branch_addr_i,
  input  logic                  fetch_valid_i,
  input  logic                  fetch_ready_i,
  input  logic                  instr_req_i,
  input  prefetch_pkg::addr_t   instr_addr_i,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  prefetch_pkg::cnt_t    fifo_cnt_i
);

  import prefetch_pkg::*;

  // Bus transactions granted but not yet answered
  cnt_t               out_cnt_q;
  logic [`PF_CNT_W:0] fill_sum;

  assign fill_sum = {1'b0, out_cnt_q} + {1'b0, fifo_cnt_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_q + cnt_t'(instr_req_i && instr_gnt_i) - cnt_t'(instr_rvalid_i);
    end
  end

  ////////////////////
  // Bus side
  ////////////////////

  a_out_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= cnt_t'(`PF_DEPTH))
    else $error("outstanding transaction count above depth");

  // Held words plus words in flight fit the buffer
  a_fill_max: assert property (@(posedge clk) disable iff (!rst_n)
    fill_sum <= (`PF_CNT_W+1)'(`PF_DEPTH))
    else $error("FIFO count plus outstanding count above depth");

  a_rvalid_owed: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (out_cnt_q != '0))
    else $error("response without an outstanding transaction");

  ////////////////////
  // Branch cycle
  ////////////////////

  a_branch_req: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |-> req_i)
    else $error("branch without fetch request");

  a_branch_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (branch_i && instr_req_i) |-> (instr_addr_i == {branch_addr_i[`PF_XLEN-1:2], 2'b00}))
    else $error("branch request not at the aligned target");

  a_no_accept_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |-> !(fetch_valid_i && fetch_ready_i))
    else $error("fetch accepted in a branch cycle");

endmodule

// File: dv/tb_prefetch_buffer.sv
`timescale 1ns/100ps
`include "prefetch_cfg.svh"

module tb_prefetch_buffer;

  import prefetch_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int STREAM_CYCLES = 200;
  localparam int BRANCH_CYCLES = 400;
  localparam int BP_LOW_CYCLES = 30;
  localparam int BP_CYCLES     = 100;
  localparam int WAIT_ROUNDS   = 4;
  localparam int WAIT_CYCLES   = 15;
  localparam int TEST_CYCLES   = 3 + STREAM_CYCLES + BRANCH_CYCLES + BP_LOW_CYCLES + BP_CYCLES +
                                 WAIT_ROUNDS * WAIT_CYCLES;

  logic   clk;
  logic   rst_n;
  logic   req;
  logic   branch;
  addr_t  branch_addr;
  logic   fetch_ready;
  logic   fetch_valid;
  instr_t fetch_rdata;
  logic   busy;
  logic   instr_req;
  addr_t  instr_addr;
  logic   instr_gnt;
  logic   instr_rvalid;
  instr_t instr_rdata;

  // Stimulus and bus memory state
  logic [31:0] lfsr_state     = 32'h626c;
  string       phase_name     = "reset";
  string       test_name      = "reset";
  logic        req_en         = 1'b0;
  logic        rand_branch_en = 1'b0;
  logic        ready_low      = 1'b0;
  logic        branch_pending = 1'b0;
  addr_t       branch_target  = '0;
  int          gnt_hold       = 0;
  int          cyc            = 0;
  int          last_due       = 0;
  addr_t       resp_addr_q[$];
  int          resp_due_q[$];

  // Comparator state
  addr_t       exp_addr    = '0;
  addr_t       wait_addr   = '0;
  logic        wait_active = 1'b0;
  logic        started     = 1'b0;
  int          outst       = 0;
  int          held        = 0;
  int          epoch       = 0;
  int          resp_tag;
  int          tag_q[$];
  int          accept_cnt  = 0;
  int          fail_cnt    = 0;

  clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  prefetch_buffer DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .busy_o         (busy),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata)
  );

  bind prefetch_buffer prefetch_assertions u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .fetch_valid_i  (fetch_valid_o),
    .fetch_ready_i  (fetch_ready_i),
    .instr_req_i    (instr_req_o),
    .instr_addr_i   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .fifo_cnt_i     (fifo_cnt)
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Memory content is the inverted byte address
  function automatic instr_t mem_word(input addr_t addr);
    return ~addr;
  endfunction

  function automatic addr_t align_word(input addr_t addr);
    return {addr[31:2], 2'b00};
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val        = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  ////////////////////
  // Failure reporting
  ////////////////////

  task automatic abort_run();
    fail_cnt++;
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("[ERROR] %s: expected 32'h%08h, actual 32'h%08h", name, expected, actual);
    abort_run();
  endtask

  task automatic describe_failure(input string what);
    $display("[ERROR] %s", what);
    abort_run();
  endtask

  ////////////////////
  // Stimulus and bus memory
  ////////////////////

  task automatic drive_cycle();
    int delay;
    int due;
    @(posedge clk);
    #1;
    cyc++;
    test_name = phase_name;
    // In-order response once its delay has elapsed
    if ((resp_due_q.size() > 0) && (resp_due_q[0] <= cyc)) begin
      instr_rvalid = 1'b1;
      instr_rdata  = mem_word(resp_addr_q.pop_front());
      void'(resp_due_q.pop_front());
    end else begin
      instr_rvalid = 1'b0;
      instr_rdata  = '0;
    end
    req    = req_en;
    branch = 1'b0;
    if (req_en && branch_pending) begin
      branch         = 1'b1;
      branch_addr    = branch_target;
      branch_pending = 1'b0;
    end else if (req_en && rand_branch_en && (take_bits(4) == 0)) begin
      branch      = 1'b1;
      branch_addr = take_bits(32);
    end
    fetch_ready = ready_low ? 1'b0 : (take_bits(3) != 0);
    // Grant withheld on demand and otherwise given three times out of four
    if (gnt_hold > 0) begin
      instr_gnt = 1'b0;
      gnt_hold--;
    end else begin
      instr_gnt = (take_bits(2) != 0);
    end
    @(negedge clk);
    if (instr_req && instr_gnt) begin
      delay = 1 + int'(take_bits(2) % 3);
      due   = cyc + delay;
      // One response per cycle keeps the order
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      resp_addr_q.push_back(instr_addr);
      resp_due_q.push_back(due);
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) drive_cycle();
  endtask

  initial begin : stimulus
    req          = 1'b0;
    branch       = 1'b0;
    branch_addr  = '0;
    fetch_ready  = 1'b0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    wait (rst_n === 1'b1);

    // Idle outputs with no fetch request
    repeat (3) begin
      drive_cycle();
      assert ({fetch_valid, instr_req, busy} == 3'b000)
        else show_mismatch("reset", 32'h0, 32'({fetch_valid, instr_req, busy}));
    end

    // Unaligned target checks the word alignment
    phase_name     = "stream";
    req_en         = 1'b1;
    branch_target  = 32'h0000_1002;
    branch_pending = 1'b1;
    run_cycles(STREAM_CYCLES);

    phase_name     = "branch";
    rand_branch_en = 1'b1;
    run_cycles(BRANCH_CYCLES);
    rand_branch_en = 1'b0;

    // Consumer stalls and the stream then resumes in order
    phase_name = "backpressure";
    ready_low  = 1'b1;
    run_cycles(BP_LOW_CYCLES);
    ready_low  = 1'b0;
    run_cycles(BP_CYCLES);

    phase_name = "branch_wait";
    repeat (WAIT_ROUNDS) begin
      branch_target  = take_bits(32);
      branch_pending = 1'b1;
      gnt_hold       = 5;
      run_cycles(WAIT_CYCLES);
    end

    // Let every transaction in flight return and every held word leave
    phase_name = "drain";
    req_en     = 1'b0;
    drive_cycle();
    while (busy || fetch_valid || (resp_addr_q.size() != 0)) begin
      drive_cycle();
    end
    // Comparator has finished the last falling edge
    @(posedge clk);

    assert (accept_cnt >= 100) else describe_failure("too few fetches were accepted");
    if (fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  ////////////////////
  // Comparator
  ////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      assert (busy == ((outst != 0) || instr_req))
        else show_mismatch("busy", 32'((outst != 0) || instr_req), 32'(busy));
      if (branch) begin
        // New epoch makes older responses stale
        epoch++;
        held        = 0;
        started     = 1'b1;
        exp_addr    = align_word(branch_addr);
        wait_addr   = exp_addr;
        wait_active = !(instr_req && instr_gnt);
        assert (!(fetch_valid && fetch_ready))
          else describe_failure("fetch accepted in a branch cycle");
        assert (!instr_req || (instr_addr == exp_addr))
          else show_mismatch("branch", exp_addr, instr_addr);
      end else if (wait_active && instr_req) begin
        // Target replayed until granted
        assert (instr_addr == wait_addr)
          else show_mismatch("branch_wait", wait_addr, instr_addr);
        wait_active = !instr_gnt;
      end
      if (instr_rvalid) begin
        resp_tag = tag_q.pop_front();
        if ((resp_tag == epoch) && !branch) begin
          held++;
        end
        outst--;
      end
      if (instr_req && instr_gnt) begin
        tag_q.push_back(epoch);
        outst++;
      end
      if (!branch && fetch_valid && fetch_ready) begin
        assert (started) else describe_failure("fetch accepted before any branch");
        assert (fetch_rdata == mem_word(exp_addr))
          else show_mismatch(test_name, mem_word(exp_addr), fetch_rdata);
        exp_addr = exp_addr + 32'd4;
        held--;
        accept_cnt++;
      end
      assert (outst + held <= `PF_DEPTH)
        else show_mismatch("backpressure", 32'(`PF_DEPTH), 32'(outst + held));
    end
  end

  // Limit scaled from the total test length
  initial begin : watchdog
    #(TEST_CYCLES * 20 * CLK_PERIOD);
    describe_failure("watchdog timeout, the run did not complete");
  end

endmodule

// File: src.f
+incdir+verilog
verilog/prefetch_pkg.sv
verilog/prefetch_ctrl.sv
verilog/fetch_fifo.sv
verilog/prefetch_buffer.sv
dv/clk_gen.sv
dv/prefetch_assertions.sv
dv/tb_prefetch_buffer.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_prefetch_buffer
FILELIST ?= src.f
BUILD    ?= obj_dir
LOG      ?= sim.log
FAIL_MSG := CHECKS FAILED
PASS_MSG := ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
